// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := tb_router_regs
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== avmm_reg_decode.sv ====
// Single-beat bus slave, answers every request one cycle later, never stalls
// Invalid addresses give a slave error; writes to read-only words are dropped
`timescale 1ns/1ps
`default_nettype none

module avmm_reg_decode import router_regs_pkg::*; (
    input  logic                     core_clk_ifc,
    input  logic                     peripheral_sresetn_core,

    input  logic                     read,
    input  logic                     write,
    input  logic [addr_w-1:0]        address,
    input  logic [data_w-1:0]        writedata,
    output logic [data_w-1:0]        readdata,
    output logic                     readdatavalid,
    output logic                     writeresponsevalid,
    output logic [1:0]               response,

    output logic [num_ing_ports-1:0] ing_port_enable,
    output logic [num_egr_ports-1:0] egr_port_enable,
    output logic [num_ing_ports-1:0] ing_sample_con,
    output logic [num_egr_ports-1:0] egr_sample_con,
    output cntr_sel_u                ing_read_sel,
    output cntr_sel_u                egr_read_sel,
    input  logic [data_w-1:0]        ing_read_word,
    input  logic [data_w-1:0]        egr_read_word
);

    logic                addr_valid;
    logic [data_w-1:0]   read_mux;

    assign addr_valid = address < addr_w'(num_regs);

    ////////////////////////////////////////
    // Writable registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            // Ports come up enabled
            ing_port_enable <= '1;
            egr_port_enable <= '1;
            ing_sample_con  <= '0;
            egr_sample_con  <= '0;
            ing_read_sel    <= '0;
            egr_read_sel    <= '0;
        end else if (write) begin
            case (address)
                addr_ing_port_enable: begin
                    ing_port_enable <= writedata[num_ing_ports-1:0];
                end
                addr_egr_port_enable: begin
                    egr_port_enable <= writedata[num_egr_ports-1:0];
                end
                addr_ing_sample_con: begin
                    ing_sample_con <= writedata[num_ing_ports-1:0];
                end
                addr_egr_sample_con: begin
                    egr_sample_con <= writedata[num_egr_ports-1:0];
                end
                // Only port and counter bytes are kept
                addr_ing_read_sel: begin
                    ing_read_sel.raw <= {16'd0, writedata[15:0]};
                end
                addr_egr_read_sel: begin
                    egr_read_sel.raw <= {16'd0, writedata[15:0]};
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Read mux

    always_comb begin
        case (address)
            addr_version_id:      read_mux = {module_version, module_id};
            addr_params:          read_mux = {8'd0, 8'(data_bytes),
                                              8'(num_egr_ports), 8'(num_ing_ports)};
            addr_ing_port_enable: read_mux = data_w'(ing_port_enable);
            addr_egr_port_enable: read_mux = data_w'(egr_port_enable);
            addr_ing_sample_con:  read_mux = data_w'(ing_sample_con);
            addr_ing_read_sel:    read_mux = ing_read_sel.raw;
            addr_ing_read_data:   read_mux = ing_read_word;
            addr_egr_sample_con:  read_mux = data_w'(egr_sample_con);
            addr_egr_read_sel:    read_mux = egr_read_sel.raw;
            addr_egr_read_data:   read_mux = egr_read_word;
            // Unmapped words read zero
            default:              read_mux = '0;
        endcase
    end

    ////////////////////////////////////////
    // Response

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
            response           <= resp_okay;
        end else begin
            readdatavalid      <= read;
            writeresponsevalid <= write;
            if (read || write) begin
                response <= addr_valid ? resp_okay : resp_slave_error;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (read) begin
            readdata <= read_mux;
        end
    end

endmodule

`default_nettype wire

// ==== drop_event_cntr.sv ====
// Counts rising edges of per-port drop levels, saturating at all ones
// A restart reloads the count with the edge seen in that same cycle
`timescale 1ns/1ps
`default_nettype none

module drop_event_cntr import router_regs_pkg::*; #(
    parameter int num_ports = num_ing_ports
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 peripheral_sresetn_core,
    input  logic [num_ports-1:0]                 drop,
    input  logic [num_ports-1:0]                 restart,
    output logic [num_ports-1:0][cnt_w-1:0]      drop_cnt
);

    logic [num_ports-1:0] drop_q;
    logic [num_ports-1:0] drop_rise;

    assign drop_rise = drop & ~drop_q;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_q   <= '0;
            drop_cnt <= '0;
        end else begin
            drop_q <= drop;
            for (int p = 0; p < num_ports; p++) begin
                // Edge in the restart cycle opens the new window
                if (restart[p]) begin
                    drop_cnt[p] <= cnt_w'(drop_rise[p]);
                end else if (drop_rise[p] && (drop_cnt[p] != '1)) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
router_regs_pkg.sv
drop_event_cntr.sv
port_cntr_bank.sv
avmm_reg_decode.sv
router_regs_top.sv
router_regs_chk.sv
tb_router_regs.sv

// ==== port_cntr_bank.sv ====
// One direction's counter bank with snapshot on rising sample bit
// Out of range port or counter selects read as zero
`timescale 1ns/1ps
`default_nettype none

module port_cntr_bank import router_regs_pkg::*; #(
    parameter int num_ports = num_ing_ports
) (
    input  logic                                                core_clk_ifc,
    input  logic                                                peripheral_sresetn_core,
    input  logic [num_ports-1:0]                                sample_con,
    input  cntr_sel_u                                           read_sel,
    input  logic [num_ports-1:0][ext_cntrs_per_port-1:0][cnt_w-1:0] ext_cnts,
    input  logic [num_ports-1:0]                                drop,
    output logic [data_w-1:0]                                   read_word
);

    localparam int port_idx_w = (num_ports > 1) ? $clog2(num_ports) : 1;
    localparam int cntr_idx_w = $clog2(cntrs_per_port);

    logic [num_ports-1:0]                                sample_q;
    logic [num_ports-1:0]                                sample_rise;
    logic [num_ports-1:0][cnt_w-1:0]                     drop_cnt;
    logic [num_ports-1:0][cntrs_per_port-1:0][cnt_w-1:0] snap;
    logic [port_idx_w-1:0]                               port_idx;
    logic [cntr_idx_w-1:0]                               cntr_idx;
    logic                                                sel_in_range;

    assign sample_rise = sample_con & ~sample_q;

    drop_event_cntr #(
        .num_ports               ( num_ports               )
    ) u_drop_cntr (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .drop                    ( drop                    ),
        .restart                 ( sample_rise             ),
        .drop_cnt                ( drop_cnt                )
    );

    ////////////////////////////////////////
    // Snapshot storage

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_q <= '0;
            snap     <= '0;
        end else begin
            sample_q <= sample_con;
            for (int p = 0; p < num_ports; p++) begin
                if (sample_rise[p]) begin
                    for (int c = 0; c < ext_cntrs_per_port; c++) begin
                        snap[p][c] <= ext_cnts[p][c];
                    end
                    // Drop count sits right after the external counters
                    snap[p][ext_cntrs_per_port] <= drop_cnt[p];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read select

    assign port_idx     = read_sel.fields.port[port_idx_w-1:0];
    assign cntr_idx     = read_sel.fields.cntr[cntr_idx_w-1:0];
    assign sel_in_range = (read_sel.fields.port < 8'(num_ports)) &&
                          (read_sel.fields.cntr < 8'(cntrs_per_port));

    assign read_word = sel_in_range ? snap[port_idx][cntr_idx] : '0;

endmodule

`default_nettype wire

// ==== router_regs_chk.sv ====
// Bus protocol assertions, bound into every router_regs_top
`timescale 1ns/1ps
`default_nettype none

module router_regs_chk (
    input logic core_clk_ifc,
    input logic peripheral_sresetn_core,
    input logic read,
    input logic write,
    input logic readdatavalid,
    input logic writeresponsevalid
);

    // Master side
    a_no_read_and_write: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) !(read && write))
        else $error("read and write asserted in the same cycle");

    ////////////////////////////////////////
    // Slave answers one cycle later

    a_read_answered: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) read |=> readdatavalid)
        else $error("read not answered by readdatavalid one cycle later");

    a_write_answered: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) write |=> writeresponsevalid)
        else $error("write not answered by writeresponsevalid one cycle later");

    a_no_spurious_read_resp: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) readdatavalid |-> $past(read))
        else $error("readdatavalid without a read");

    a_no_spurious_write_resp: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) writeresponsevalid |-> $past(write))
        else $error("writeresponsevalid without a write");

endmodule

bind router_regs_top router_regs_chk u_chk (.*);

`default_nettype wire

// ==== router_regs_pkg.sv ====
// Register map and shared constants for the router CSR block
// Word addresses only, one clock domain, no bursts or byte enables
`default_nettype none

package router_regs_pkg;

    ////////////////////////////////////////
    // Widths and sizes

    localparam int data_w             = 32;
    localparam int addr_w             = 4;
    localparam int cnt_w              = 32;
    localparam int num_ing_ports      = 11;
    localparam int num_egr_ports      = 11;
    // Packet 0, byte 1, error 2, drop 3
    localparam int cntrs_per_port     = 4;
    localparam int ext_cntrs_per_port = 3;

    // Identification and parameter word values
    localparam bit [15:0] module_version = 16'h0100;
    localparam bit [15:0] module_id      = 16'd10;
    localparam int        mtu_bytes      = 2000;
    localparam int        data_bytes     = 64;

    ////////////////////////////////////////
    // Word address map

    localparam bit [addr_w-1:0] addr_version_id      = 4'd0;
    localparam bit [addr_w-1:0] addr_params          = 4'd1;
    localparam bit [addr_w-1:0] addr_ing_port_enable = 4'd2;
    localparam bit [addr_w-1:0] addr_egr_port_enable = 4'd3;
    localparam bit [addr_w-1:0] addr_ing_sample_con  = 4'd4;
    localparam bit [addr_w-1:0] addr_ing_read_sel    = 4'd5;
    localparam bit [addr_w-1:0] addr_ing_read_data   = 4'd6;
    localparam bit [addr_w-1:0] addr_egr_sample_con  = 4'd7;
    localparam bit [addr_w-1:0] addr_egr_read_sel    = 4'd8;
    localparam bit [addr_w-1:0] addr_egr_read_data   = 4'd9;
    localparam int              num_regs             = 10;

    localparam bit [1:0] resp_okay        = 2'b00;
    localparam bit [1:0] resp_slave_error = 2'b10;

    // Read select word, seen raw by the decoder and as fields by a bank
    typedef struct packed {
        logic [15:0] unused;
        logic [7:0]  port;
        logic [7:0]  cntr;
    } cntr_sel_fields_t;

    typedef union packed {
        logic [data_w-1:0] raw;
        cntr_sel_fields_t  fields;
    } cntr_sel_u;

endpackage

`default_nettype wire

// ==== router_regs_top.sv ====
// Router CSR block top, one bus slave and an ingress and an egress bank
// All logic runs on core_clk_ifc with a synchronous active-low reset
`timescale 1ns/1ps
`default_nettype none

module router_regs_top import router_regs_pkg::*; (
    input  logic                     core_clk_ifc,
    input  logic                     peripheral_sresetn_core,

    input  logic                     read,
    input  logic                     write,
    input  logic [addr_w-1:0]        address,
    input  logic [data_w-1:0]        writedata,
    output logic [data_w-1:0]        readdata,
    output logic                     readdatavalid,
    output logic                     writeresponsevalid,
    output logic [1:0]               response,

    output logic [num_ing_ports-1:0] ing_port_enable,
    output logic [num_egr_ports-1:0] egr_port_enable,
    input  logic [num_ing_ports-1:0][ext_cntrs_per_port-1:0][cnt_w-1:0] ing_cnts,
    input  logic [num_egr_ports-1:0][ext_cntrs_per_port-1:0][cnt_w-1:0] egr_cnts,
    input  logic [num_ing_ports-1:0] ing_buf_overflow,
    input  logic [num_egr_ports-1:0] egr_buf_full_drop
);

    logic [num_ing_ports-1:0] ing_sample_con;
    logic [num_egr_ports-1:0] egr_sample_con;
    cntr_sel_u                ing_read_sel;
    cntr_sel_u                egr_read_sel;
    logic [data_w-1:0]        ing_read_word;
    logic [data_w-1:0]        egr_read_word;

    avmm_reg_decode u_decode (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .read                    ( read                    ),
        .write                   ( write                   ),
        .address                 ( address                 ),
        .writedata               ( writedata               ),
        .readdata                ( readdata                ),
        .readdatavalid           ( readdatavalid           ),
        .writeresponsevalid      ( writeresponsevalid      ),
        .response                ( response                ),
        .ing_port_enable         ( ing_port_enable         ),
        .egr_port_enable         ( egr_port_enable         ),
        .ing_sample_con          ( ing_sample_con          ),
        .egr_sample_con          ( egr_sample_con          ),
        .ing_read_sel            ( ing_read_sel            ),
        .egr_read_sel            ( egr_read_sel            ),
        .ing_read_word           ( ing_read_word           ),
        .egr_read_word           ( egr_read_word           )
    );

    // Ingress drops are buffer overflows
    port_cntr_bank #(
        .num_ports               ( num_ing_ports           )
    ) u_ing_bank (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_con              ( ing_sample_con          ),
        .read_sel                ( ing_read_sel            ),
        .ext_cnts                ( ing_cnts                ),
        .drop                    ( ing_buf_overflow        ),
        .read_word               ( ing_read_word           )
    );

    // Egress drops are buffer-full discards
    port_cntr_bank #(
        .num_ports               ( num_egr_ports           )
    ) u_egr_bank (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_con              ( egr_sample_con          ),
        .read_sel                ( egr_read_sel            ),
        .ext_cnts                ( egr_cnts                ),
        .drop                    ( egr_buf_full_drop       ),
        .read_word               ( egr_read_word           )
    );

endmodule

`default_nettype wire

// ==== tb_router_regs.sv ====
// Testbench for the router CSR block with all results checked against a register model
// Bus requests are spaced two cycles apart so a read always sees earlier writes
`timescale 1ns/1ps
`default_nettype none

module tb_router_regs import router_regs_pkg::*; ();

    localparam time clk_period = 40;
    localparam int  max_ports  = (num_ing_ports > num_egr_ports) ? num_ing_ports : num_egr_ports;
    // Reset, random writes, invalid space, sampling, drop counting
    localparam int  num_bus_ops = 10 + 64 + 22 + 2 * 2 * (2 + 2 * 47) + 2 * (66 + 4 + 4 * 11);
    localparam time watchdog_time = num_bus_ops * 4 * clk_period + 100 * clk_period;

    localparam logic [addr_w-1:0] samp_addr [2] = '{addr_ing_sample_con, addr_egr_sample_con};
    localparam logic [addr_w-1:0] sel_addr  [2] = '{addr_ing_read_sel, addr_egr_read_sel};
    localparam logic [addr_w-1:0] data_addr [2] = '{addr_ing_read_data, addr_egr_read_data};

    logic                     core_clk_ifc;
    logic                     peripheral_sresetn_core;
    logic                     read;
    logic                     write;
    logic [addr_w-1:0]        address;
    logic [data_w-1:0]        writedata;
    logic [data_w-1:0]        readdata;
    logic                     readdatavalid;
    logic                     writeresponsevalid;
    logic [1:0]               response;
    logic [num_ing_ports-1:0] ing_port_enable;
    logic [num_egr_ports-1:0] egr_port_enable;
    logic [num_ing_ports-1:0][ext_cntrs_per_port-1:0][cnt_w-1:0] ing_cnts;
    logic [num_egr_ports-1:0][ext_cntrs_per_port-1:0][cnt_w-1:0] egr_cnts;
    logic [num_ing_ports-1:0] ing_buf_overflow;
    logic [num_egr_ports-1:0] egr_buf_full_drop;

    // Register model with index 0 for ingress and 1 for egress
    logic [max_ports-1:0] m_en   [2];
    logic [max_ports-1:0] m_samp [2];
    logic [31:0]          m_sel  [2];
    logic [cnt_w-1:0]     m_snap [2][max_ports][cntrs_per_port];
    int                   m_drop [2][max_ports];

    // Expected answers in request order as {is_read, response, data}
    logic [34:0] exp_q [$];
    int          seed = 79008;
    int          errors = 0;
    int          checks = 0;
    int          test_num = 0;
    int          err_mark = 0;

    router_regs_top u_router_regs_top (.*);

    always #(clk_period / 2) core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////
    // Model

    function automatic int nports(input int d);
        return (d == 0) ? num_ing_ports : num_egr_ports;
    endfunction

    function automatic logic [max_ports-1:0] port_mask(input int d);
        logic [max_ports-1:0] mask;
        mask = '0;
        for (int p = 0; p < nports(d); p++) mask[p] = 1'b1;
        return mask;
    endfunction

    function automatic logic [cnt_w-1:0] ext_cnt(input int d, input int p, input int c);
        return (d == 0) ? ing_cnts[p][c] : egr_cnts[p][c];
    endfunction

    function automatic logic [33:0] expected_read(input logic [addr_w-1:0] addr);
        int          d;
        logic [31:0] sel;
        d   = (addr >= addr_egr_sample_con) ? 1 : 0;
        sel = m_sel[d];
        case (addr)
            addr_version_id: return {resp_okay, module_version, module_id};
            addr_params: return {resp_okay, 8'd0, 8'(data_bytes), 8'(num_egr_ports),
                                 8'(num_ing_ports)};
            addr_ing_port_enable: return {resp_okay, 32'(m_en[0])};
            addr_egr_port_enable: return {resp_okay, 32'(m_en[1])};
            addr_ing_sample_con, addr_egr_sample_con: return {resp_okay, 32'(m_samp[d])};
            addr_ing_read_sel, addr_egr_read_sel: return {resp_okay, m_sel[d]};
            addr_ing_read_data, addr_egr_read_data: begin
                if (int'(sel[15:8]) < nports(d) && int'(sel[7:0]) < cntrs_per_port) begin
                    return {resp_okay, m_snap[d][int'(sel[15:8])][int'(sel[7:0])]};
                end
                return {resp_okay, 32'd0};
            end
            default: return {resp_slave_error, 32'd0};
        endcase
    endfunction

    function automatic void model_write(input logic [addr_w-1:0] addr, input logic [31:0] data);
        int                   d;
        logic [max_ports-1:0] rise;
        d = (addr == addr_egr_port_enable || addr >= addr_egr_sample_con) ? 1 : 0;
        case (addr)
            addr_ing_port_enable, addr_egr_port_enable: begin
                m_en[d] = data[max_ports-1:0] & port_mask(d);
            end
            addr_ing_sample_con, addr_egr_sample_con: begin
                // A rising sample bit snapshots the port and restarts its drop count
                rise = data[max_ports-1:0] & port_mask(d) & ~m_samp[d];
                for (int p = 0; p < nports(d); p++) begin
                    if (rise[p]) begin
                        for (int c = 0; c < ext_cntrs_per_port; c++) begin
                            m_snap[d][p][c] = ext_cnt(d, p, c);
                        end
                        m_snap[d][p][ext_cntrs_per_port] = cnt_w'(m_drop[d][p]);
                        m_drop[d][p] = 0;
                    end
                end
                m_samp[d] = data[max_ports-1:0] & port_mask(d);
            end
            addr_ing_read_sel, addr_egr_read_sel: m_sel[d] = {16'd0, data[15:0]};
            default: begin
            end
        endcase
    endfunction

    ////////////////////////////////////////
    // Bus and stimulus tasks

    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [31:0] data);
        @(posedge core_clk_ifc);
        write     <= 1'b1;
        address   <= addr;
        writedata <= data;
        exp_q.push_back({1'b0, (int'(addr) < num_regs) ? resp_okay : resp_slave_error, 32'd0});
        model_write(addr, data);
        @(posedge core_clk_ifc);
        write <= 1'b0;
    endtask

    task automatic bus_read(input logic [addr_w-1:0] addr);
        @(posedge core_clk_ifc);
        read    <= 1'b1;
        address <= addr;
        exp_q.push_back({1'b1, expected_read(addr)});
        @(posedge core_clk_ifc);
        read <= 1'b0;
    endtask

    task automatic read_cntr(input int d, input int p, input int c);
        bus_write(sel_addr[d], {16'd0, 8'(p), 8'(c)});
        bus_read(data_addr[d]);
    endtask

    task automatic randomize_cnts(input int d);
        @(posedge core_clk_ifc);
        for (int p = 0; p < nports(d); p++) begin
            for (int c = 0; c < ext_cntrs_per_port; c++) begin
                if (d == 0) ing_cnts[p][c] <= $random(seed);
                else egr_cnts[p][c] <= $random(seed);
            end
        end
    endtask

    task automatic pulse_drop(input int d, input int p);
        @(posedge core_clk_ifc);
        if (d == 0) ing_buf_overflow[p] <= 1'b1;
        else egr_buf_full_drop[p] <= 1'b1;
        @(posedge core_clk_ifc);
        if (d == 0) ing_buf_overflow[p] <= 1'b0;
        else egr_buf_full_drop[p] <= 1'b0;
        @(posedge core_clk_ifc);
        m_drop[d][p]++;
    endtask

    task automatic sample_all(input int d);
        bus_write(samp_addr[d], 32'd0);
        bus_write(samp_addr[d], 32'hffff_ffff);
        repeat (2) @(posedge core_clk_ifc);
    endtask

    ////////////////////////////////////////
    // Checking

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic check_enables();
        @(negedge core_clk_ifc);
        checks += 2;
        assert (ing_port_enable == m_en[0][num_ing_ports-1:0])
            else report_mismatch("ing_port_enable", 32'(ing_port_enable), 32'(m_en[0]));
        assert (egr_port_enable == m_en[1][num_egr_ports-1:0])
            else report_mismatch("egr_port_enable", 32'(egr_port_enable), 32'(m_en[1]));
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(negedge core_clk_ifc);
        test_num++;
        $display("Test %0d %s: %0d errors", test_num, name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(negedge core_clk_ifc) begin
        logic [34:0] want;
        if (peripheral_sresetn_core && (readdatavalid || writeresponsevalid)) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("Error at %0t ns: bus response with no request outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (readdatavalid == want[34])
                    else report_mismatch("readdatavalid", 32'(readdatavalid), 32'(want[34]));
                assert (writeresponsevalid == !want[34])
                    else report_mismatch("writeresponsevalid", 32'(writeresponsevalid),
                                         32'(!want[34]));
                assert (response == want[33:32])
                    else report_mismatch("response", 32'(response), 32'(want[33:32]));
                if (want[34]) begin
                    assert (readdata == want[31:0])
                        else report_mismatch("readdata", readdata, want[31:0]);
                end
            end
        end
    end

    initial begin
        #(watchdog_time);
        $display("Timeout: the bus responses did not complete in the expected time");
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // Tests

    initial begin
        core_clk_ifc            = 1'b0;
        peripheral_sresetn_core = 1'b0;
        read                    = 1'b0;
        write                   = 1'b0;
        address                 = '0;
        writedata               = '0;
        ing_cnts                = '0;
        egr_cnts                = '0;
        ing_buf_overflow        = '0;
        egr_buf_full_drop       = '0;
        for (int d = 0; d < 2; d++) begin
            m_en[d]   = port_mask(d);
            m_samp[d] = '0;
            m_sel[d]  = '0;
            for (int p = 0; p < max_ports; p++) begin
                m_drop[d][p] = 0;
                for (int c = 0; c < cntrs_per_port; c++) m_snap[d][p][c] = '0;
            end
        end
        repeat (2) @(posedge core_clk_ifc);
        peripheral_sresetn_core <= 1'b1;

        check_enables();
        for (int a = 0; a < num_regs; a++) bus_read(addr_w'(a));
        end_test("reset values");

        repeat (4) begin
            for (int a = 0; a < num_regs; a++) begin
                if (a != int'(addr_ing_read_data) && a != int'(addr_egr_read_data)) begin
                    bus_write(addr_w'(a), $random(seed));
                    check_enables();
                    bus_read(addr_w'(a));
                end
            end
        end
        end_test("random register writes");

        for (int a = num_regs; a < 16; a++) begin
            bus_write(addr_w'(a), $random(seed));
            bus_read(addr_w'(a));
        end
        for (int a = 0; a < num_regs; a++) bus_read(addr_w'(a));
        end_test("invalid addresses");

        for (int d = 0; d < 2; d++) begin
            repeat (2) begin
                randomize_cnts(d);
                bus_write(samp_addr[d], 32'd0);
                bus_write(samp_addr[d], $random(seed));
                repeat (2) @(posedge core_clk_ifc);
                for (int p = 0; p < nports(d); p++) begin
                    for (int c = 0; c < cntrs_per_port; c++) read_cntr(d, p, c);
                end
                read_cntr(d, nports(d), 0);
                read_cntr(d, 0, cntrs_per_port);
                read_cntr(d, 255, 255);
            end
        end
        end_test("counter sampling");

        for (int d = 0; d < 2; d++) begin
            for (int p = 0; p < nports(d); p++) begin
                repeat (p + 1) pulse_drop(d, p);
            end
            repeat (2) @(posedge core_clk_ifc);
            sample_all(d);
            for (int p = 0; p < nports(d); p++) read_cntr(d, p, ext_cntrs_per_port);
            // No pulses since the last sample
            sample_all(d);
            for (int p = 0; p < nports(d); p++) read_cntr(d, p, ext_cntrs_per_port);
        end
        end_test("drop counting");

        $display("Tests run: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
